// ==== Makefile ====
# Verilator build, run and lint for the USB receiver testbench

VERILATOR  ?= verilator
TOP        ?= tb_usb_rx
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= No errors
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== list.f ====
usb_rx_pkg.sv
usb_rx_line.sv
usb_rx_byte.sv
usb_rx_crc.sv
usb_rx_ctrl.sv
usb_rx.sv
tb_usb_rx_assert.sv
tb_usb_rx.sv

// ==== tb_usb_rx.sv ====
// assumes 8 clocks per bit and one packet per table row; stops at the first mismatch
`timescale 1ns/1ps

module tb_usb_rx;

  localparam int CLKS_PER_BIT = 8;
  localparam int CLK_NS       = 4;
  localparam int LEAD_BITS    = 4;
  // J bits after SE0 so the last pulse can land
  localparam int GAP_BITS     = 4;
  localparam int NUM_ROWS     = 18;
  localparam usb_rx_pkg::addr_t DEV_ADDR = 7'h15;
  localparam usb_rx_pkg::endp_t DEV_ENDP = 4'h3;

  // corruption applied to a row
  typedef enum logic [2:0] {
    C_NONE,
    C_SYNC,
    C_CPL,
    C_CRC,
    C_TRUNC,
    C_STUFF
  } corrupt_t;

  typedef struct packed {
    logic [3:0]            pid;
    logic [7:0]            len;
    corrupt_t              kind;
    usb_rx_pkg::addr_t     addr;
    usb_rx_pkg::endp_t     endp;
    logic [1:0]            n_exp;
    usb_rx_pkg::pkt_code_t exp0;
    usb_rx_pkg::pkt_code_t exp1;
  } row_t;

  // ******************************
  // stimulus table
  // ******************************
  localparam row_t ROWS [NUM_ROWS] = '{
    '{usb_rx_pkg::PID_ACK, 8'd0, C_NONE, DEV_ADDR, DEV_ENDP,
      2'd1, usb_rx_pkg::PKT_ACK, usb_rx_pkg::PKT_IDLE},
    '{usb_rx_pkg::PID_NAK, 8'd0, C_NONE, DEV_ADDR, DEV_ENDP,
      2'd1, usb_rx_pkg::PKT_NAK, usb_rx_pkg::PKT_IDLE},
    '{usb_rx_pkg::PID_STALL, 8'd0, C_NONE, DEV_ADDR, DEV_ENDP,
      2'd1, usb_rx_pkg::PKT_STALL, usb_rx_pkg::PKT_IDLE},
    '{usb_rx_pkg::PID_IN, 8'd0, C_NONE, DEV_ADDR, DEV_ENDP,
      2'd1, usb_rx_pkg::PKT_IN, usb_rx_pkg::PKT_IDLE},
    '{usb_rx_pkg::PID_OUT, 8'd0, C_NONE, DEV_ADDR, DEV_ENDP,
      2'd1, usb_rx_pkg::PKT_OUT, usb_rx_pkg::PKT_IDLE},
    '{usb_rx_pkg::PID_IN, 8'd0, C_NONE, 7'h16, DEV_ENDP,
      2'd0, usb_rx_pkg::PKT_IDLE, usb_rx_pkg::PKT_IDLE},
    '{usb_rx_pkg::PID_OUT, 8'd0, C_NONE, DEV_ADDR, 4'h4,
      2'd0, usb_rx_pkg::PKT_IDLE, usb_rx_pkg::PKT_IDLE},
    '{usb_rx_pkg::PID_IN, 8'd0, C_CRC, DEV_ADDR, DEV_ENDP,
      2'd1, usb_rx_pkg::PKT_BAD, usb_rx_pkg::PKT_IDLE},
    '{usb_rx_pkg::PID_DATA0, 8'd4, C_NONE, DEV_ADDR, DEV_ENDP,
      2'd1, usb_rx_pkg::PKT_DATA, usb_rx_pkg::PKT_IDLE},
    '{usb_rx_pkg::PID_DATA1, 8'd8, C_NONE, DEV_ADDR, DEV_ENDP,
      2'd1, usb_rx_pkg::PKT_DATA, usb_rx_pkg::PKT_IDLE},
    '{usb_rx_pkg::PID_DATA0, 8'd0, C_NONE, DEV_ADDR, DEV_ENDP,
      2'd1, usb_rx_pkg::PKT_DATA, usb_rx_pkg::PKT_IDLE},
    '{usb_rx_pkg::PID_DATA1, 8'd5, C_CRC, DEV_ADDR, DEV_ENDP,
      2'd2, usb_rx_pkg::PKT_DATA, usb_rx_pkg::PKT_BAD},
    '{usb_rx_pkg::PID_ACK, 8'd0, C_SYNC, DEV_ADDR, DEV_ENDP,
      2'd0, usb_rx_pkg::PKT_IDLE, usb_rx_pkg::PKT_IDLE},
    '{4'b0101, 8'd0, C_NONE, DEV_ADDR, DEV_ENDP,
      2'd0, usb_rx_pkg::PKT_IDLE, usb_rx_pkg::PKT_IDLE},
    '{usb_rx_pkg::PID_ACK, 8'd0, C_CPL, DEV_ADDR, DEV_ENDP,
      2'd1, usb_rx_pkg::PKT_BAD, usb_rx_pkg::PKT_IDLE},
    '{usb_rx_pkg::PID_ACK, 8'd0, C_TRUNC, DEV_ADDR, DEV_ENDP,
      2'd1, usb_rx_pkg::PKT_BAD, usb_rx_pkg::PKT_IDLE},
    '{usb_rx_pkg::PID_ACK, 8'd0, C_STUFF, DEV_ADDR, DEV_ENDP,
      2'd1, usb_rx_pkg::PKT_BAD, usb_rx_pkg::PKT_IDLE},
    // a clean packet last shows the receiver recovered
    '{usb_rx_pkg::PID_ACK, 8'd0, C_NONE, DEV_ADDR, DEV_ENDP,
      2'd1, usb_rx_pkg::PKT_ACK, usb_rx_pkg::PKT_IDLE}
  };

  logic                  tb_clk;
  logic                  rst_n;
  logic                  d_plus;
  logic                  d_minus;
  usb_rx_pkg::pkt_code_t rx_packet;
  logic                  store_data;
  usb_rx_pkg::byte_t     rx_data;

  // unstuffed bits of one packet with sync first
  logic                  bits_q [$];
  usb_rx_pkg::byte_t     exp_bytes [$];
  usb_rx_pkg::pkt_code_t got_codes [$];
  usb_rx_pkg::byte_t     got_bytes [$];
  // current NRZI level of d_plus
  logic                  line_dp;

  initial tb_clk = 1'b0;
  always #(CLK_NS / 2) tb_clk = ~tb_clk;

  usb_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .DEV_ADDR    (DEV_ADDR),
    .DEV_ENDP    (DEV_ENDP)
  ) dut0 (
    .tb_clk    (tb_clk),
    .rst_n     (rst_n),
    .d_plus    (d_plus),
    .d_minus   (d_minus),
    .rx_packet (rx_packet),
    .store_data(store_data),
    .rx_data   (rx_data)
  );

  // ******************************
  // error reporting and compares
  // ******************************
  task automatic report_error(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_code(input string sig, input usb_rx_pkg::pkt_code_t got,
                            input usb_rx_pkg::pkt_code_t exp);
    if (got !== exp) begin
      report_error($sformatf("CHECK FAILED time %0t %s got %s (%0d) expected %s (%0d)",
                             $time, sig, got.name(), got, exp.name(), exp));
    end
  endtask

  task automatic check_byte(input string sig, input usb_rx_pkg::byte_t got,
                            input usb_rx_pkg::byte_t exp);
    if (got !== exp) begin
      report_error($sformatf("CHECK FAILED time %0t %s got %02h expected %02h",
                             $time, sig, got, exp));
    end
  endtask

  // assertion failures from the bound checker
  always @(dut0.assert_u0.fail_cnt) begin
    if (dut0.assert_u0.fail_cnt != 0) begin
      report_error("a bound assertion on the DUT outputs failed");
    end
  end

  // ******************************
  // packet building
  // ******************************
  function automatic void put_byte(input usb_rx_pkg::byte_t b);
    // MSB goes on the wire first
    for (int i = 7; i >= 0; i--) begin
      bits_q.push_back(b[i]);
    end
  endfunction

  // preset to ones and fed MSB first from index first to the queue end
  function automatic logic [15:0] crc_calc(input int first, input int width,
                                           input logic [15:0] poly);
    logic [15:0] crc;
    logic        fb;
    crc = 16'hFFFF;
    for (int i = first; i < bits_q.size(); i++) begin
      fb  = bits_q[i] ^ crc[width-1];
      crc = (crc << 1) ^ (fb ? poly : 16'h0000);
    end
    return crc & ((16'h0001 << width) - 16'h0001);
  endfunction

  task automatic build_packet(input row_t r);
    int                first;
    logic [15:0]       crc;
    usb_rx_pkg::byte_t b;
    bits_q.delete();
    exp_bytes.delete();
    put_byte((r.kind == C_SYNC) ? 8'h00 : usb_rx_pkg::SYNC_BYTE);
    if (r.kind == C_CPL) begin
      put_byte({r.pid, r.pid});
    end else begin
      put_byte({r.pid, ~r.pid});
    end
    // CRC covers everything after the PID
    first = bits_q.size();
    if ((r.pid == usb_rx_pkg::PID_IN) || (r.pid == usb_rx_pkg::PID_OUT)) begin
      for (int i = 6; i >= 0; i--) begin
        bits_q.push_back(r.addr[i]);
      end
      for (int i = 3; i >= 0; i--) begin
        bits_q.push_back(r.endp[i]);
      end
      crc = crc_calc(first, usb_rx_pkg::CRC5_W, 16'(usb_rx_pkg::CRC5_POLY));
      for (int i = 4; i >= 0; i--) begin
        bits_q.push_back((r.kind == C_CRC) ? 1'b0 : ~crc[i]);
      end
    end else if ((r.pid == usb_rx_pkg::PID_DATA0) || (r.pid == usb_rx_pkg::PID_DATA1)) begin
      for (int i = 0; i < int'(r.len); i++) begin
        b = usb_rx_pkg::byte_t'($urandom());
        exp_bytes.push_back(b);
        put_byte(b);
      end
      crc = crc_calc(first, usb_rx_pkg::CRC16_W, usb_rx_pkg::CRC16_POLY);
      crc = (r.kind == C_CRC) ? 16'h0000 : ~crc;
      put_byte(crc[15:8]);
      put_byte(crc[7:0]);
    end
    // EOP lands in the middle of the PID
    if (r.kind == C_TRUNC) begin
      repeat (4) void'(bits_q.pop_back());
    end
    // sent without stuffing so seven ones occur in a row
    if (r.kind == C_STUFF) begin
      put_byte(8'hFF);
    end
  endtask

  // ******************************
  // line encoder
  // ******************************
  task automatic drive_line(input logic dp, input logic dm);
    repeat (CLKS_PER_BIT) begin
      @(posedge tb_clk);
      d_plus  <= dp;
      d_minus <= dm;
    end
  endtask

  // a zero toggles the level and a one holds it
  task automatic nrzi_bit(input logic b);
    if (!b) begin
      line_dp = ~line_dp;
    end
    drive_line(line_dp, ~line_dp);
  endtask

  task automatic send_packet(input logic stuff_on);
    int ones;
    ones    = 0;
    line_dp = 1'b1;
    foreach (bits_q[i]) begin
      nrzi_bit(bits_q[i]);
      ones = bits_q[i] ? ones + 1 : 0;
      if (stuff_on && (ones == int'(usb_rx_pkg::STUFF_RUN))) begin
        nrzi_bit(1'b0);
        ones = 0;
      end
    end
    // EOP is two bits of SE0 then J
    repeat (2) drive_line(1'b0, 1'b0);
    repeat (GAP_BITS) drive_line(1'b1, 1'b0);
  endtask

  // ******************************
  // monitors and row check
  // ******************************
  always @(negedge tb_clk) begin
    if (rst_n) begin
      if (rx_packet != usb_rx_pkg::PKT_IDLE) begin
        got_codes.push_back(rx_packet);
      end
      if (store_data) begin
        got_bytes.push_back(rx_data);
      end
    end
  end

  task automatic check_row(input int idx, input row_t r);
    usb_rx_pkg::pkt_code_t exp_codes [$];
    if (r.n_exp != 2'd0) begin
      exp_codes.push_back(r.exp0);
    end
    if (r.n_exp == 2'd2) begin
      exp_codes.push_back(r.exp1);
    end
    if (got_codes.size() != exp_codes.size()) begin
      report_error($sformatf("row %0d gave %0d packet codes where %0d were expected",
                             idx, got_codes.size(), exp_codes.size()));
    end
    foreach (exp_codes[i]) begin
      check_code("rx_packet", got_codes[i], exp_codes[i]);
    end
    if (got_bytes.size() != exp_bytes.size()) begin
      report_error($sformatf("row %0d gave %0d payload bytes where %0d were expected",
                             idx, got_bytes.size(), exp_bytes.size()));
    end
    foreach (exp_bytes[i]) begin
      check_byte("rx_data", got_bytes[i], exp_bytes[i]);
    end
    got_codes.delete();
    got_bytes.delete();
  endtask

  // upper bound on wire bits for one row with stuffing and gap
  function automatic int row_bits(input row_t r);
    int n;
    n = 16;
    if ((r.pid == usb_rx_pkg::PID_IN) || (r.pid == usb_rx_pkg::PID_OUT)) begin
      n = n + 16;
    end else if ((r.pid == usb_rx_pkg::PID_DATA0) || (r.pid == usb_rx_pkg::PID_DATA1)) begin
      n = n + 8 * int'(r.len) + 16;
    end
    if (r.kind == C_STUFF) begin
      n = n + 8;
    end
    return n + n / int'(usb_rx_pkg::STUFF_RUN) + 2 + GAP_BITS;
  endfunction

  initial begin : watchdog
    int total_bits;
    int limit_ns;
    total_bits = LEAD_BITS;
    for (int i = 0; i < NUM_ROWS; i++) begin
      total_bits = total_bits + row_bits(ROWS[i]);
    end
    limit_ns = 2 * (total_bits * CLKS_PER_BIT * CLK_NS + 2 * CLK_NS);
    #(limit_ns);
    report_error($sformatf("timeout, the test did not finish within %0d ns", limit_ns));
  end

  // ******************************
  // main sequence
  // ******************************
  initial begin
    void'($urandom(13));
    rst_n   = 1'b0;
    d_plus  = 1'b1;
    d_minus = 1'b0;
    line_dp = 1'b1;
    repeat (2) @(posedge tb_clk);
    rst_n <= 1'b1;
    // idle J before the first sync
    repeat (LEAD_BITS) drive_line(1'b1, 1'b0);
    for (int i = 0; i < NUM_ROWS; i++) begin
      build_packet(ROWS[i]);
      send_packet(ROWS[i].kind != C_STUFF);
      check_row(i, ROWS[i]);
    end
    $display("No errors");
    $finish;
  end

endmodule

// ==== tb_usb_rx_assert.sv ====
// sampled on rising tb_clk; the pulse-width check is off while rst_n is low
`timescale 1ns/1ps

module tb_usb_rx_assert (
  input logic                  tb_clk,
  input logic                  rst_n,
  input usb_rx_pkg::pkt_code_t rx_packet,
  input logic                  store_data
);

  // count of failed assertions
  int unsigned fail_cnt = 0;

  // class codes are single-cycle pulses
  pulse_one_cycle: assert property (
    @(posedge tb_clk) disable iff (!rst_n)
    (rx_packet != usb_rx_pkg::PKT_IDLE) |=> (rx_packet == usb_rx_pkg::PKT_IDLE)
  ) else begin
    fail_cnt = fail_cnt + 1;
    $error("rx_packet held a non-idle code for more than one cycle");
  end

  no_store_in_reset: assert property (
    @(posedge tb_clk) !rst_n |-> !store_data
  ) else begin
    fail_cnt = fail_cnt + 1;
    $error("store_data high while rst_n is low");
  end

  // first cycle out of reset
  idle_after_reset: assert property (
    @(posedge tb_clk)
    $rose(rst_n) |-> ((rx_packet == usb_rx_pkg::PKT_IDLE) && !store_data)
  ) else begin
    fail_cnt = fail_cnt + 1;
    $error("outputs not idle in the cycle after reset");
  end

endmodule

bind usb_rx tb_usb_rx_assert assert_u0 (
  .tb_clk    (tb_clk),
  .rst_n     (rst_n),
  .rx_packet (rx_packet),
  .store_data(store_data)
);

// ==== usb_rx.sv ====
// full-speed receive path only; rx_packet and store_data are one-clock strobes
`timescale 1ns/1ps

module usb_rx #(
  parameter int                CLKS_PER_BIT = 8,
  parameter usb_rx_pkg::addr_t DEV_ADDR     = '0,
  parameter usb_rx_pkg::endp_t DEV_ENDP     = '0
) (
  input  logic                  tb_clk,
  input  logic                  rst_n,
  input  logic                  d_plus,
  input  logic                  d_minus,
  output usb_rx_pkg::pkt_code_t rx_packet,
  output logic                  store_data,
  output usb_rx_pkg::byte_t     rx_data
);

  // ******************************
  // line to byte
  // ******************************
  logic              bit_valid;
  logic              bit_val;
  logic              eop;

  // byte to control and CRC
  logic              byte_valid;
  usb_rx_pkg::byte_t rx_byte;
  logic              pkt_start;
  logic              bit_valid_out;
  logic              bit_out;
  logic              aligned;
  logic              stuff_err;

  // CRC results and restart
  logic              crc_clear;
  logic              crc5_ok;
  logic              crc16_ok;

  usb_rx_line #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) line_u0 (
    .tb_clk   (tb_clk),
    .rst_n    (rst_n),
    .d_plus   (d_plus),
    .d_minus  (d_minus),
    .bit_valid(bit_valid),
    .bit_val  (bit_val),
    .eop      (eop)
  );

  usb_rx_byte byte_u0 (
    .tb_clk       (tb_clk),
    .rst_n        (rst_n),
    .bit_valid    (bit_valid),
    .bit_val      (bit_val),
    .eop          (eop),
    .byte_valid   (byte_valid),
    .rx_byte      (rx_byte),
    .pkt_start    (pkt_start),
    .bit_valid_out(bit_valid_out),
    .bit_out      (bit_out),
    .aligned      (aligned),
    .stuff_err    (stuff_err)
  );

  // token check
  usb_rx_crc #(
    .WIDTH   (usb_rx_pkg::CRC5_W),
    .POLY    (usb_rx_pkg::CRC5_POLY),
    .RESIDUAL(usb_rx_pkg::CRC5_RESIDUAL)
  ) crc5_u0 (
    .tb_clk   (tb_clk),
    .rst_n    (rst_n),
    .clear    (crc_clear),
    .bit_valid(bit_valid_out),
    .bit_in   (bit_out),
    .crc_ok   (crc5_ok)
  );

  // data check
  usb_rx_crc #(
    .WIDTH   (usb_rx_pkg::CRC16_W),
    .POLY    (usb_rx_pkg::CRC16_POLY),
    .RESIDUAL(usb_rx_pkg::CRC16_RESIDUAL)
  ) crc16_u0 (
    .tb_clk   (tb_clk),
    .rst_n    (rst_n),
    .clear    (crc_clear),
    .bit_valid(bit_valid_out),
    .bit_in   (bit_out),
    .crc_ok   (crc16_ok)
  );

  usb_rx_ctrl #(
    .DEV_ADDR(DEV_ADDR),
    .DEV_ENDP(DEV_ENDP)
  ) ctrl_u0 (
    .tb_clk    (tb_clk),
    .rst_n     (rst_n),
    .pkt_start (pkt_start),
    .byte_valid(byte_valid),
    .rx_byte   (rx_byte),
    .eop       (eop),
    .aligned   (aligned),
    .stuff_err (stuff_err),
    .crc5_ok   (crc5_ok),
    .crc16_ok  (crc16_ok),
    .crc_clear (crc_clear),
    .rx_packet (rx_packet),
    .store_data(store_data),
    .rx_data   (rx_data)
  );

endmodule

// ==== usb_rx_byte.sv ====
// SYNC is only found after an idle bit; a one after six ones ends the packet
`timescale 1ns/1ps

module usb_rx_byte (
  input  logic              tb_clk,
  input  logic              rst_n,
  input  logic              bit_valid,
  input  logic              bit_val,
  input  logic              eop,
  output logic              byte_valid,
  output usb_rx_pkg::byte_t rx_byte,
  output logic              pkt_start,
  output logic              bit_valid_out,
  output logic              bit_out,
  output logic              aligned,
  output logic              stuff_err
);

  // inside a packet, past SYNC
  logic              in_pkt;
  // idle bit plus sync pattern
  logic [8:0]        hunt_sr;
  logic [8:0]        hunt_next;
  logic [2:0]        ones_cnt;
  logic [2:0]        bit_cnt;
  usb_rx_pkg::byte_t shift_sr;
  // next bit should be a stuffed zero
  logic              stuff_slot;
  logic              take_bit;

  assign hunt_next  = {hunt_sr[7:0], bit_val};
  assign stuff_slot = (ones_cnt == usb_rx_pkg::STUFF_RUN);
  assign take_bit   = bit_valid && in_pkt && !stuff_slot;
  assign aligned    = (bit_cnt == 3'd0);

  // ******************************
  // hunt, unstuff, count
  // ******************************
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      in_pkt        <= 1'b0;
      hunt_sr       <= '1;
      ones_cnt      <= 3'd0;
      bit_cnt       <= 3'd0;
      pkt_start     <= 1'b0;
      byte_valid    <= 1'b0;
      bit_valid_out <= 1'b0;
      stuff_err     <= 1'b0;
    end else begin
      pkt_start     <= 1'b0;
      byte_valid    <= 1'b0;
      bit_valid_out <= 1'b0;
      stuff_err     <= 1'b0;
      if (eop) begin
        // back to hunt, window looks like idle
        in_pkt   <= 1'b0;
        hunt_sr  <= '1;
        ones_cnt <= 3'd0;
        bit_cnt  <= 3'd0;
      end else if (bit_valid) begin
        if (!in_pkt) begin
          hunt_sr <= hunt_next;
          if (hunt_next == {1'b1, usb_rx_pkg::SYNC_BYTE}) begin
            pkt_start <= 1'b1;
            in_pkt    <= 1'b1;
            bit_cnt   <= 3'd0;
            // sync ends in a one, it counts toward stuffing
            ones_cnt  <= {2'b00, bit_val};
          end
        end else if (stuff_slot) begin
          // stuffed zero dropped here
          ones_cnt <= 3'd0;
          if (bit_val) begin
            stuff_err <= 1'b1;
            in_pkt    <= 1'b0;
            hunt_sr   <= '0;
            bit_cnt   <= 3'd0;
          end
        end else begin
          bit_valid_out <= 1'b1;
          ones_cnt      <= bit_val ? ones_cnt + 3'd1 : 3'd0;
          // wraps at byte boundary
          bit_cnt       <= bit_cnt + 3'd1;
          byte_valid    <= (bit_cnt == 3'd7);
        end
      end
    end
  end

  // byte assembly, first bit lands in the MSB
  always_ff @(posedge tb_clk) begin
    if (take_bit) begin
      bit_out  <= bit_val;
      shift_sr <= {shift_sr[6:0], bit_val};
      if (bit_cnt == 3'd7) begin
        rx_byte <= {shift_sr[6:0], bit_val};
      end
    end
  end

endmodule

// ==== usb_rx_crc.sv ====
// serial CRC, MSB first, preset to ones; crc_ok only holds meaning at packet end
`timescale 1ns/1ps

module usb_rx_crc #(
  parameter int               WIDTH    = 5,
  parameter logic [WIDTH-1:0] POLY     = '0,
  parameter logic [WIDTH-1:0] RESIDUAL = '0
) (
  input  logic tb_clk,
  input  logic rst_n,
  input  logic clear,
  input  logic bit_valid,
  input  logic bit_in,
  output logic crc_ok
);

  logic [WIDTH-1:0] crc_q;
  // top bit out xor new bit
  logic             feedback;

  assign feedback = bit_in ^ crc_q[WIDTH-1];

  // ******************************
  // shift register
  // ******************************
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      crc_q <= '1;
    end else if (clear) begin
      // clear wins over a bit in the same cycle
      crc_q <= '1;
    end else if (bit_valid) begin
      crc_q <= {crc_q[WIDTH-2:0], 1'b0} ^ (feedback ? POLY : '0);
    end
  end

  // a good packet including its inverted CRC leaves the fixed residual
  assign crc_ok = (crc_q == RESIDUAL);

endmodule

// ==== usb_rx_ctrl.sv ====
// classifies at EOP; no response is sent and payload bytes leave without back-pressure
`timescale 1ns/1ps

module usb_rx_ctrl #(
  parameter usb_rx_pkg::addr_t DEV_ADDR = '0,
  parameter usb_rx_pkg::endp_t DEV_ENDP = '0
) (
  input  logic                  tb_clk,
  input  logic                  rst_n,
  input  logic                  pkt_start,
  input  logic                  byte_valid,
  input  usb_rx_pkg::byte_t     rx_byte,
  input  logic                  eop,
  input  logic                  aligned,
  input  logic                  stuff_err,
  input  logic                  crc5_ok,
  input  logic                  crc16_ok,
  output logic                  crc_clear,
  output usb_rx_pkg::pkt_code_t rx_packet,
  output logic                  store_data,
  output usb_rx_pkg::byte_t     rx_data
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_PID,
    S_TOKEN,
    S_DATA,
    S_HSHAKE,
    S_DRAIN
  } state_t;

  state_t                state;
  // bytes after the PID, saturates at 3
  logic [1:0]            byte_cnt;
  // code to report at EOP for tokens and handshakes
  usb_rx_pkg::pkt_code_t pend_code;
  usb_rx_pkg::pkt_code_t eop_code;
  // two-deep hold, hold1 is the older byte
  usb_rx_pkg::byte_t     hold0;
  usb_rx_pkg::byte_t     hold1;
  usb_rx_pkg::pid_t      pid_rx;
  logic                  pid_ok;
  usb_rx_pkg::addr_t     tok_addr;
  usb_rx_pkg::endp_t     tok_endp;
  logic                  tok_match;
  logic                  in_pkt;
  logic                  release_byte;

  // PID nibble first, complement second
  assign pid_rx = usb_rx_pkg::pid_t'(rx_byte[7:4]);
  assign pid_ok = (rx_byte[7:4] == ~rx_byte[3:0]);

  // token bytes sit in the hold at EOP
  assign tok_addr  = hold1[7:1];
  assign tok_endp  = {hold1[0], hold0[7:5]};
  assign tok_match = (tok_addr == DEV_ADDR) && (tok_endp == DEV_ENDP);

  assign in_pkt = (state == S_PID) || (state == S_TOKEN) ||
                  (state == S_DATA) || (state == S_HSHAKE);
  // third byte on pushes the oldest out, the last two stay behind as CRC
  assign release_byte = (state == S_DATA) && byte_valid && byte_cnt[1];

  // ******************************
  // classification at EOP
  // ******************************
  always_comb begin
    eop_code = usb_rx_pkg::PKT_IDLE;
    if (!aligned) begin
      eop_code = usb_rx_pkg::PKT_BAD;
    end else begin
      case (state)
        S_TOKEN: begin
          if ((byte_cnt != 2'd2) || !crc5_ok) begin
            eop_code = usb_rx_pkg::PKT_BAD;
          end else if (tok_match) begin
            eop_code = pend_code;
          end
        end
        S_HSHAKE: begin
          eop_code = (byte_cnt == 2'd0) ? pend_code : usb_rx_pkg::PKT_BAD;
        end
        S_DATA: begin
          // DATA already reported, only a failure adds a code
          if (!byte_cnt[1] || !crc16_ok) begin
            eop_code = usb_rx_pkg::PKT_BAD;
          end
        end
        default: begin
          eop_code = usb_rx_pkg::PKT_IDLE;
        end
      endcase
    end
  end

  // ******************************
  // packet FSM
  // ******************************
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      byte_cnt   <= 2'd0;
      pend_code  <= usb_rx_pkg::PKT_IDLE;
      rx_packet  <= usb_rx_pkg::PKT_IDLE;
      store_data <= 1'b0;
      crc_clear  <= 1'b0;
    end else begin
      rx_packet  <= usb_rx_pkg::PKT_IDLE;
      store_data <= release_byte;
      crc_clear  <= pkt_start;
      if (in_pkt && eop) begin
        rx_packet <= eop_code;
        state     <= S_IDLE;
      end else if (in_pkt && stuff_err) begin
        // wait out the rest of the packet
        rx_packet <= usb_rx_pkg::PKT_BAD;
        state     <= S_DRAIN;
      end else begin
        case (state)
          S_IDLE: begin
            if (pkt_start) begin
              state    <= S_PID;
              byte_cnt <= 2'd0;
            end
          end
          S_PID: begin
            if (byte_valid) begin
              // restart both CRCs so the PID is left out
              crc_clear <= 1'b1;
              if (!pid_ok) begin
                rx_packet <= usb_rx_pkg::PKT_BAD;
                state     <= S_DRAIN;
              end else begin
                case (pid_rx)
                  usb_rx_pkg::PID_OUT: begin
                    pend_code <= usb_rx_pkg::PKT_OUT;
                    state     <= S_TOKEN;
                  end
                  usb_rx_pkg::PID_IN: begin
                    pend_code <= usb_rx_pkg::PKT_IN;
                    state     <= S_TOKEN;
                  end
                  usb_rx_pkg::PID_DATA0, usb_rx_pkg::PID_DATA1: begin
                    rx_packet <= usb_rx_pkg::PKT_DATA;
                    state     <= S_DATA;
                  end
                  usb_rx_pkg::PID_ACK: begin
                    pend_code <= usb_rx_pkg::PKT_ACK;
                    state     <= S_HSHAKE;
                  end
                  usb_rx_pkg::PID_NAK: begin
                    pend_code <= usb_rx_pkg::PKT_NAK;
                    state     <= S_HSHAKE;
                  end
                  usb_rx_pkg::PID_STALL: begin
                    pend_code <= usb_rx_pkg::PKT_STALL;
                    state     <= S_HSHAKE;
                  end
                  // unknown PID, silently ignored
                  default: begin
                    state <= S_DRAIN;
                  end
                endcase
              end
            end
          end
          S_TOKEN, S_DATA, S_HSHAKE: begin
            if (byte_valid && (byte_cnt != 2'd3)) begin
              byte_cnt <= byte_cnt + 2'd1;
            end
          end
          S_DRAIN: begin
            if (eop) begin
              state <= S_IDLE;
            end
          end
          default: begin
            state <= S_IDLE;
          end
        endcase
      end
    end
  end

  // payload delay line
  always_ff @(posedge tb_clk) begin
    if (byte_valid) begin
      hold1 <= hold0;
      hold0 <= rx_byte;
    end
    if (release_byte) begin
      rx_data <= hold1;
    end
  end

endmodule

// ==== usb_rx_line.sv ====
// needs CLKS_PER_BIT >= 4; any SE0 of one bit or more followed by J counts as EOP
`timescale 1ns/1ps

module usb_rx_line #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic tb_clk,
  input  logic rst_n,
  input  logic d_plus,
  input  logic d_minus,
  output logic bit_valid,
  output logic bit_val,
  output logic eop
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] CNT_MID = CNT_W'(CLKS_PER_BIT / 2);

  // two-flop synchronizers, index 1 is the safe copy
  logic [1:0]       dp_sync;
  logic [1:0]       dm_sync;
  // previous synced levels, for edge detect
  logic             dp_q;
  logic             dm_q;
  logic [CNT_W-1:0] bit_cnt;
  // level of the last decoded bit
  logic             last_dp;
  // SE0 bit periods seen, saturating
  logic [1:0]       se0_cnt;
  logic             line_edge;
  logic             line_se0;
  logic             sample;

  assign line_edge = (dp_sync[1] != dp_q) || (dm_sync[1] != dm_q);
  assign line_se0  = !dp_sync[1] && !dm_sync[1];
  // mid-bit, counted from the last edge
  assign sample    = (bit_cnt == CNT_MID) && !line_edge;

  // ******************************
  // synchronizer, idle is J
  // ******************************
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      dp_sync <= 2'b11;
      dm_sync <= 2'b00;
      dp_q    <= 1'b1;
      dm_q    <= 1'b0;
    end else begin
      dp_sync <= {dp_sync[0], d_plus};
      dm_sync <= {dm_sync[0], d_minus};
      dp_q    <= dp_sync[1];
      dm_q    <= dm_sync[1];
    end
  end

  // bit timer, restarted on every line edge
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= '0;
    end else if (line_edge || (bit_cnt == CNT_LAST)) begin
      bit_cnt <= '0;
    end else begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // ******************************
  // NRZI decode and EOP
  // ******************************
  always_ff @(posedge tb_clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_valid <= 1'b0;
      eop       <= 1'b0;
      last_dp   <= 1'b1;
      se0_cnt   <= 2'd0;
    end else begin
      bit_valid <= 1'b0;
      eop       <= 1'b0;
      if (sample) begin
        if (line_se0) begin
          // no bit strobe during SE0
          if (se0_cnt != 2'd3) begin
            se0_cnt <= se0_cnt + 2'd1;
          end
        end else if ((se0_cnt != 2'd0) && dp_sync[1]) begin
          // J after SE0, line back to idle
          eop     <= 1'b1;
          se0_cnt <= 2'd0;
          last_dp <= 1'b1;
        end else begin
          se0_cnt   <= 2'd0;
          bit_valid <= 1'b1;
          last_dp   <= dp_sync[1];
        end
      end
    end
  end

  // no change of level decodes as one
  always_ff @(posedge tb_clk) begin
    if (sample && !line_se0) begin
      bit_val <= (dp_sync[1] == last_dp);
    end
  end

endmodule

// ==== usb_rx_pkg.sv ====
// bit order and PID nibble order follow the reference bench (PID first, bytes MSB first)
package usb_rx_pkg;

  // ******************************
  // widths
  // ******************************
  localparam int BYTE_W  = 8;
  localparam int PKT_W   = 3;
  localparam int PID_W   = 4;
  localparam int ADDR_W  = 7;
  localparam int ENDP_W  = 4;
  localparam int CRC5_W  = 5;
  localparam int CRC16_W = 16;

  // one received byte
  typedef logic [BYTE_W-1:0] byte_t;

  // device address and endpoint fields of a token
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [ENDP_W-1:0] endp_t;

  // ******************************
  // packet class on rx_packet
  // ******************************
  typedef enum logic [PKT_W-1:0] {
    PKT_IDLE  = 3'd0,
    PKT_DATA  = 3'd1,
    PKT_OUT   = 3'd2,
    PKT_IN    = 3'd3,
    PKT_ACK   = 3'd4,
    PKT_NAK   = 3'd5,
    PKT_BAD   = 3'd6,
    PKT_STALL = 3'd7
  } pkt_code_t;

  // PID codes in the upper nibble, complement in the lower one
  // SOF, SETUP and PRE are not decoded
  typedef enum logic [PID_W-1:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110
  } pid_t;

  // ******************************
  // line framing
  // ******************************
  // KJKJKJKK decoded as bits, last eight of the sync field
  localparam byte_t SYNC_BYTE = 8'h01;

  // ones in a row before a stuffed zero
  localparam logic [2:0] STUFF_RUN = 3'd6;

  // ******************************
  // CRC constants
  // ******************************
  // x^5 + x^2 + 1, seeded with ones, sent inverted
  localparam logic [CRC5_W-1:0]  CRC5_POLY      = 5'b00101;
  localparam logic [CRC5_W-1:0]  CRC5_RESIDUAL  = 5'b01100;
  // x^16 + x^15 + x^2 + 1
  localparam logic [CRC16_W-1:0] CRC16_POLY     = 16'h8005;
  localparam logic [CRC16_W-1:0] CRC16_RESIDUAL = 16'h800D;

endpackage
